//--- common/lane_operand_if.sv
`default_nettype none

// One aligned operand line, from operand_fetch to every lane.
interface lane_operand_if #(
    parameter int LANES = 4
);
    import update_pkg::*;

    logic              valid;
    lane_t             gradient;   // Same scalar for all lanes.
    lane_t [LANES-1:0] samples;
    lane_t [LANES-1:0] models;

    modport source (
        output valid,
        output gradient,
        output samples,
        output models
    );

    modport sink (
        input valid,
        input gradient,
        input samples,
        input models
    );

endinterface

`default_nettype wire

//--- common/update_pkg.sv
`default_nettype none

package update_pkg;

    // Lane value in signed Q16.16.
    localparam int LANE_WIDTH = 32;
    localparam int FRAC_BITS  = 16;

    typedef logic signed [LANE_WIDTH-1:0] lane_t;

    // Line and iteration counts.
    typedef logic [15:0] count_t;

    // Model memory line address.
    typedef logic [15:0] addr_t;

    // Cycles from model_re to valid model_rdata. Fixed by the memory.
    localparam int MEM_LATENCY = 1;

    // Cycles from operand valid to lane result valid.
    localparam int LANE_LATENCY = 2;

endpackage

`default_nettype wire

//--- rtl/glm_update_top.sv
`default_nettype none

module glm_update_top #(
    parameter int LANES           = 4,
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     sample_we,
    input  logic [LANES*update_pkg::LANE_WIDTH-1:0] sample_data,
    output logic                                     sample_full,
    input  logic                                     gradient_we,
    input  logic [update_pkg::LANE_WIDTH-1:0]       gradient_data,
    output logic                                     gradient_full,
    input  update_pkg::count_t                       num_lines,
    input  update_pkg::count_t                       num_iterations,
    input  update_pkg::addr_t                        read_offset,
    input  update_pkg::addr_t                        write_offset,
    output logic                                     model_re,
    output update_pkg::addr_t                        model_raddr,
    input  logic [LANES*update_pkg::LANE_WIDTH-1:0] model_rdata,
    output logic                                     model_we,
    output update_pkg::addr_t                        model_waddr,
    output logic [LANES*update_pkg::LANE_WIDTH-1:0] model_wdata,
    input  logic                                     model_almost_full,
    input  logic                                     op_start,
    output logic                                     op_done
);
    import update_pkg::*;

    typedef lane_t [LANES-1:0] line_t;

    line_t            sample_line;
    lane_t            gradient;
    logic             sample_empty;
    logic             gradient_empty;
    logic             sample_pop;
    logic             gradient_pop;
    logic [LANES-1:0] lane_valid;
    line_t            lane_result;

    lane_operand_if #(.LANES(LANES)) lane_operands ();

    sync_fifo #(
        .payload_t      (line_t),
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) u_sample_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (sample_we),
        .push_data(sample_data),
        .pop      (sample_pop),
        .pop_data (sample_line),
        .empty    (sample_empty),
        .full     (sample_full)
    );

    sync_fifo #(
        .payload_t      (lane_t),
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) u_gradient_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (gradient_we),
        .push_data(gradient_data),
        .pop      (gradient_pop),
        .pop_data (gradient),
        .empty    (gradient_empty),
        .full     (gradient_full)
    );

    operand_fetch #(.LANES(LANES)) u_operand_fetch (
        .clk              (clk),
        .reset            (reset),
        .op_start         (op_start),
        .num_lines        (num_lines),
        .num_iterations   (num_iterations),
        .read_offset      (read_offset),
        .sample_empty     (sample_empty),
        .gradient_empty   (gradient_empty),
        .sample_pop       (sample_pop),
        .gradient_pop     (gradient_pop),
        .sample_line      (sample_line),
        .gradient         (gradient),
        .model_almost_full(model_almost_full),
        .model_re         (model_re),
        .model_raddr      (model_raddr),
        .model_rdata      (model_rdata),
        .operands         (lane_operands.source)
    );

    for (genvar i = 0; i < LANES; i++)
    begin : g_lane
        update_lane #(.LANE_INDEX(i)) u_update_lane (
            .clk         (clk),
            .reset       (reset),
            .operands    (lane_operands.sink),
            .result_valid(lane_valid[i]),
            .result      (lane_result[i])
        );
    end

    writeback #(.LANES(LANES)) u_writeback (
        .clk           (clk),
        .reset         (reset),
        .op_start      (op_start),
        .num_lines     (num_lines),
        .num_iterations(num_iterations),
        .write_offset  (write_offset),
        .lane_valid    (lane_valid),
        .lane_result   (lane_result),
        .model_we      (model_we),
        .model_waddr   (model_waddr),
        .model_wdata   (model_wdata),
        .op_done       (op_done)
    );

endmodule

`default_nettype wire

//--- rtl/sync_fifo.sv
`default_nettype none

module sync_fifo #(
    parameter type payload_t     = update_pkg::lane_t,
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);
    localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

    payload_t mem [DEPTH];

    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
    logic [FIFO_DEPTH_LOG2:0]   count;
    logic                       do_push;
    logic                       do_pop;

    assign do_push = push && !full;   // Push while full is dropped.
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = count[FIFO_DEPTH_LOG2];   // Top bit set only at DEPTH.

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and output register.
    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
        if (do_pop)
        begin
            pop_data <= mem[rd_ptr];   // Valid the cycle after pop.
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module glm_update_tb \
    -f sources.f \
    --Mdir obj_dir -o glm_update_sim

./obj_dir/glm_update_sim

//--- sources.f
common/update_pkg.sv
common/lane_operand_if.sv
rtl/sync_fifo.sv
update_core/operand_fetch.sv
update_core/update_lane.sv
update_core/writeback.sv
rtl/glm_update_top.sv
tb/glm_update_properties.sv
tb/glm_update_tb.sv

//--- tb/glm_update_properties.sv
`default_nettype none

module glm_update_properties (
    input logic clk,
    input logic reset,
    input logic op_start,
    input logic model_re,
    input logic model_we,
    input logic model_almost_full,
    input logic op_done
);
    logic seen_start;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            seen_start <= 1'b0;
        end
        else if (op_start)
        begin
            seen_start <= 1'b1;
        end
    end

    // No new read while the write side is near full.
    no_read_when_almost_full: assert property (@(posedge clk) disable iff (reset)
        model_almost_full |-> !model_re)
        else $error("model_re issued while model_almost_full was high");

    write_four_after_read: assert property (@(posedge clk) disable iff (reset)
        model_we |-> $past(model_re, 4))
        else $error("model_we without a model_re exactly 4 cycles earlier");

    // Quiet through reset and up to the first op_start.
    quiet_until_start: assert property (@(posedge clk)
        (reset || !seen_start) |-> !(model_re || model_we || op_done))
        else $error("activity on model_re, model_we or op_done before op_start");

    done_with_final_write: assert property (@(posedge clk) disable iff (reset)
        op_done |-> model_we)
        else $error("op_done pulsed without a write in the same cycle");

endmodule

bind glm_update_top glm_update_properties u_properties (
    .clk              (clk),
    .reset            (reset),
    .op_start         (op_start),
    .model_re         (model_re),
    .model_we         (model_we),
    .model_almost_full(model_almost_full),
    .op_done          (op_done)
);

`default_nettype wire

//--- tb/glm_update_tb.sv
`default_nettype none

module glm_update_tb;
    import update_pkg::*;

    localparam int LANES      = 4;
    localparam int LW         = LANES * LANE_WIDTH;
    localparam int DEPTH_LOG2 = 4;
    localparam int FIFO_DEPTH = 2 ** DEPTH_LOG2;
    localparam int TIMEOUT    = 2000;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  sample_we;
    logic [LW-1:0]         sample_data;
    logic                  sample_full;
    logic                  gradient_we;
    logic [LANE_WIDTH-1:0] gradient_data;
    logic                  gradient_full;
    count_t                num_lines;
    count_t                num_iterations;
    addr_t                 read_offset;
    addr_t                 write_offset;
    logic                  model_re;
    addr_t                 model_raddr;
    logic [LW-1:0]         model_rdata;
    logic                  model_we;
    addr_t                 model_waddr;
    logic [LW-1:0]         model_wdata;
    logic                  model_almost_full;
    logic                  op_start;
    logic                  op_done;

    logic [LW-1:0] mem [256];   // Model memory, reads and writes.
    logic [LW-1:0] sample_q [$];
    lane_t         grad_q [$];
    logic [LW-1:0] exp_data [$];
    addr_t         exp_addr [$];
    logic [3:0]    re_hist;
    logic          rd_re;
    addr_t         rd_addr;
    logic          started;
    logic          op_running;
    int            op_lines;
    int            af_rate;
    int            gap_rate;
    int            seed;
    int            sample_count;   // Expected FIFO occupancy.
    int            grad_count;
    int            read_line;

    glm_update_top #(.LANES(LANES), .FIFO_DEPTH_LOG2(DEPTH_LOG2)) UUT (.*);

    task automatic report_mismatch(input string msg);
        $display("Fail at time %0t: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at the first failed check.");
    endtask

    function automatic lane_t update_value(input lane_t model, input lane_t grad,
                                           input lane_t sample);
        logic signed [2*LANE_WIDTH-1:0] product;
        product = grad * sample;   // Full signed product.
        return model - lane_t'(product >>> FRAC_BITS);
    endfunction

    task automatic run_op(input int lines, input int iters, input int rd, input int wr,
                          input int af, input int gap);
        logic [LW-1:0] line;
        logic [LW-1:0] result;
        lane_t         g;
        int            cycles;
        repeat (2) @(posedge clk);
        @(negedge clk);
        for (int k = 0; k < iters; k++)
        begin
            g = $random(seed);
            grad_q.push_back(g);
            for (int j = 0; j < lines; j++)
            begin
                for (int l = 0; l < LANES; l++)
                begin
                    line[l*LANE_WIDTH +: LANE_WIDTH]   = $random(seed);
                    result[l*LANE_WIDTH +: LANE_WIDTH] = update_value(
                        mem[rd+j][l*LANE_WIDTH +: LANE_WIDTH], g,
                        line[l*LANE_WIDTH +: LANE_WIDTH]);
                end
                sample_q.push_back(line);
                exp_data.push_back(result);
                exp_addr.push_back(addr_t'(wr + j));
            end
        end
        op_lines   = lines;
        af_rate    = af;
        gap_rate   = gap;
        op_running = 1'b1;
        @(posedge clk);
        #1;
        num_lines      = count_t'(lines);
        num_iterations = count_t'(iters);
        read_offset    = addr_t'(rd);
        write_offset   = addr_t'(wr);
        op_start       = 1'b1;
        @(posedge clk);
        #1;
        op_start = 1'b0;
        started  = 1'b1;
        cycles   = 0;
        while (!op_done)
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT)
            begin
                $display("CHECKS FAILED");
                $fatal(1, "Timed out waiting for op_done.");
            end
        end
        @(negedge clk);
        op_running = 1'b0;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Memory read data, back-pressure and both producers.
    always @(posedge clk)
    begin
        rd_re   = model_re;
        rd_addr = model_raddr;
        #1;
        if (rd_re)
        begin
            model_rdata = mem[rd_addr[7:0]];
        end
        model_almost_full = ({$random(seed)} % 100 < af_rate) && op_running;
        sample_we = 1'b0;
        if ({$random(seed)} % 100 >= gap_rate && !sample_full && sample_q.size() != 0)
        begin
            sample_we   = 1'b1;
            sample_data = sample_q.pop_front();
        end
        gradient_we = 1'b0;
        // Next gradient only once the previous iteration's samples are out.
        if ({$random(seed)} % 100 >= gap_rate && !gradient_full && grad_q.size() != 0
            && sample_q.size() <= op_lines * grad_q.size())
        begin
            gradient_we   = 1'b1;
            gradient_data = grad_q.pop_front();
        end
    end

    // Mid-cycle, ahead of the bound properties.
    always @(negedge clk)
    begin
        re_hist <= reset ? 4'b0 : {re_hist[2:0], model_re};
        assert (started || !(model_re || model_we || op_done))
            else report_mismatch("activity before the first op_start");
        assert (!(model_re && model_almost_full))
            else report_mismatch("model_re while model_almost_full is high");
        assert (!op_done || model_we)
            else report_mismatch("op_done without a write");
        assert (sample_full == (sample_count == FIFO_DEPTH))
            else report_mismatch("sample_full does not match the FIFO occupancy");
        assert (gradient_full == (grad_count == FIFO_DEPTH))
            else report_mismatch("gradient_full does not match the FIFO occupancy");
        if (model_re)
        begin
            assert (model_raddr == read_offset + addr_t'(read_line))
                else report_mismatch($sformatf("read addr %0d, expected %0d", model_raddr,
                                               read_offset + addr_t'(read_line)));
        end
        if (model_we)
        begin
            assert (re_hist[3])
                else report_mismatch("write not 4 cycles after its read");
            assert (exp_addr.size() != 0 && model_waddr == exp_addr[0]
                    && model_wdata == exp_data[0])
                else report_mismatch($sformatf("write addr %0d data %h, expected %0d data %h",
                                               model_waddr, model_wdata,
                                               exp_addr[0], exp_data[0]));
            assert (op_done == (exp_addr.size() == 1))
                else report_mismatch("op_done not in the cycle of the final write");
            mem[model_waddr[7:0]] = model_wdata;
            exp_addr.delete(0);
            exp_data.delete(0);
        end
        if (reset)
        begin
            sample_count = 0;
            grad_count   = 0;
            read_line    = 0;
        end
        else
        begin
            sample_count = sample_count + int'(sample_we) - int'(model_re);
            grad_count   = grad_count + int'(gradient_we)
                         - int'(model_re && read_line == 0);
            if (model_re)
            begin
                read_line = (read_line == op_lines - 1) ? 0 : read_line + 1;
            end
        end
    end

    initial
    begin
        seed              = 45;
        reset             = 1'b1;
        sample_we         = 1'b0;
        sample_data       = '0;
        gradient_we       = 1'b0;
        gradient_data     = '0;
        num_lines         = '0;
        num_iterations    = '0;
        read_offset       = '0;
        write_offset      = '0;
        model_rdata       = '0;
        model_almost_full = 1'b0;
        op_start          = 1'b0;
        started           = 1'b0;
        op_running        = 1'b0;
        op_lines          = 0;
        af_rate           = 0;
        gap_rate          = 0;
        for (int i = 0; i < 256; i++)
        begin
            for (int l = 0; l < LANES; l++)
            begin
                mem[i][l*LANE_WIDTH +: LANE_WIDTH] = $random(seed);
            end
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        run_op(4, 1, 0, 64, 0, 0);      // Single iteration.
        run_op(5, 3, 16, 80, 0, 0);     // Gradient per iteration.
        run_op(8, 2, 32, 96, 40, 0);    // Random almost-full.
        run_op(6, 3, 48, 112, 20, 70);  // Slow producers, late gradients.
        run_op(20, 1, 128, 160, 90, 0); // Sample FIFO fills up.
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- update_core/operand_fetch.sv
`default_nettype none

module operand_fetch #(
    parameter int LANES = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          op_start,
    input  update_pkg::count_t            num_lines,
    input  update_pkg::count_t            num_iterations,
    input  update_pkg::addr_t             read_offset,
    input  logic                          sample_empty,
    input  logic                          gradient_empty,
    output logic                          sample_pop,
    output logic                          gradient_pop,
    input  update_pkg::lane_t [LANES-1:0] sample_line,
    input  update_pkg::lane_t             gradient,
    input  logic                          model_almost_full,
    output logic                          model_re,
    output update_pkg::addr_t             model_raddr,
    input  update_pkg::lane_t [LANES-1:0] model_rdata,
    lane_operand_if.source                operands
);
    import update_pkg::*;

    // Writeback stays busy this many cycles after the last issue.
    localparam int DRAIN_CYCLES = MEM_LATENCY + LANE_LATENCY;
    localparam int DRAIN_W      = $clog2(DRAIN_CYCLES + 1);

    logic               busy;
    logic [DRAIN_W-1:0] drain_cnt;
    count_t             line_cnt;
    count_t             iter_cnt;
    count_t             cfg_num_lines;
    count_t             cfg_num_iterations;
    addr_t              cfg_read_offset;
    logic               start;
    logic               issue;
    logic               last_line;
    logic               last_iter;

    assign start = op_start && !busy && (drain_cnt == '0);

    // Gradient only needed at the head of an iteration.
    assign issue = busy
                && (line_cnt < cfg_num_lines)
                && !sample_empty
                && !model_almost_full
                && (line_cnt != '0 || !gradient_empty);

    assign last_line = (line_cnt == cfg_num_lines - 1'b1);
    assign last_iter = (iter_cnt == cfg_num_iterations - 1'b1);

    assign model_re     = issue;
    assign model_raddr  = cfg_read_offset + line_cnt;
    assign sample_pop   = issue;
    assign gradient_pop = issue && (line_cnt == '0);

    // FIFO outputs and model_rdata all land one cycle after the issue.
    // The gradient FIFO output holds until the next iteration's pop.
    assign operands.gradient = gradient;
    assign operands.samples  = sample_line;
    assign operands.models   = model_rdata;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy           <= 1'b0;
            drain_cnt      <= '0;
            line_cnt       <= '0;
            iter_cnt       <= '0;
            operands.valid <= 1'b0;
        end
        else
        begin
            operands.valid <= issue;

            if (drain_cnt != '0)
            begin
                drain_cnt <= drain_cnt - 1'b1;
            end

            if (start)
            begin
                busy     <= 1'b1;
                line_cnt <= '0;
                iter_cnt <= '0;
            end
            else if (issue)
            begin
                if (last_line)
                begin
                    line_cnt <= '0;
                    if (last_iter)
                    begin
                        busy      <= 1'b0;
                        drain_cnt <= DRAIN_W'(DRAIN_CYCLES);
                    end
                    else
                    begin
                        iter_cnt <= iter_cnt + 1'b1;
                    end
                end
                else
                begin
                    line_cnt <= line_cnt + 1'b1;
                end
            end
        end
    end

    // Configuration, sampled on an accepted op_start.
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            cfg_num_lines      <= num_lines;
            cfg_num_iterations <= num_iterations;
            cfg_read_offset    <= read_offset;
        end
    end

endmodule

`default_nettype wire

//--- update_core/update_lane.sv
`default_nettype none

module update_lane #(
    parameter int LANE_INDEX = 0
) (
    input  logic              clk,
    input  logic              reset,
    lane_operand_if.sink      operands,
    output logic              result_valid,
    output update_pkg::lane_t result
);
    import update_pkg::*;

    logic signed [2*LANE_WIDTH-1:0] full_product;
    lane_t                          product_q;
    lane_t                          model_q;
    logic                           valid_q;

    assign full_product = $signed(operands.gradient)
                        * $signed(operands.samples[LANE_INDEX]);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_q      <= 1'b0;
            result_valid <= 1'b0;
        end
        else
        begin
            valid_q      <= operands.valid;
            result_valid <= valid_q;
        end
    end

    always_ff @(posedge clk)
    begin
        // Stage 1. Q16.16 product, arithmetic shift then truncate.
        product_q <= full_product[FRAC_BITS +: LANE_WIDTH];
        model_q   <= operands.models[LANE_INDEX];
        // Stage 2. Wrapping subtract.
        result    <= model_q - product_q;
    end

endmodule

`default_nettype wire

//--- update_core/writeback.sv
`default_nettype none

module writeback #(
    parameter int LANES = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          op_start,
    input  update_pkg::count_t            num_lines,
    input  update_pkg::count_t            num_iterations,
    input  update_pkg::addr_t             write_offset,
    input  logic [LANES-1:0]              lane_valid,
    input  update_pkg::lane_t [LANES-1:0] lane_result,
    output logic                          model_we,
    output update_pkg::addr_t             model_waddr,
    output update_pkg::lane_t [LANES-1:0] model_wdata,
    output logic                          op_done
);
    import update_pkg::*;

    logic   busy;
    count_t line_cnt;
    count_t iter_cnt;
    count_t cfg_num_lines;
    count_t cfg_num_iterations;
    addr_t  cfg_write_offset;
    logic   start;
    logic   line_valid;
    logic   write;

    assign start = op_start && !busy;

    // Lanes run in lockstep.
    assign line_valid = &lane_valid;
    assign write      = busy && line_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy     <= 1'b0;
            line_cnt <= '0;
            iter_cnt <= '0;
            model_we <= 1'b0;
            op_done  <= 1'b0;
        end
        else
        begin
            model_we <= write;
            op_done  <= 1'b0;

            if (start)
            begin
                busy     <= 1'b1;
                line_cnt <= '0;
                iter_cnt <= '0;
            end
            else if (write)
            begin
                if (line_cnt == cfg_num_lines - 1'b1)
                begin
                    line_cnt <= '0;
                    if (iter_cnt == cfg_num_iterations - 1'b1)
                    begin
                        op_done <= 1'b1;   // Same cycle as the final model_we.
                        busy    <= 1'b0;
                    end
                    else
                    begin
                        iter_cnt <= iter_cnt + 1'b1;
                    end
                end
                else
                begin
                    line_cnt <= line_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            cfg_num_lines      <= num_lines;
            cfg_num_iterations <= num_iterations;
            cfg_write_offset   <= write_offset;
        end
        if (write)
        begin
            model_waddr <= cfg_write_offset + line_cnt;
            model_wdata <= lane_result;
        end
    end

endmodule

`default_nettype wire
